/* common/portalBusPkg.sv */
`default_nettype none

package portalBusPkg;

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH = 6;
  localparam int LEN_WIDTH = 4;
  localparam int OFFSET_WIDTH = 5;
  localparam int RESP_WIDTH = 2;

  typedef logic [ADDR_WIDTH-1:0] busAddrT;
  typedef logic [DATA_WIDTH-1:0] busDataT;
  typedef logic [ID_WIDTH-1:0] busIdT;
  // Burst length minus one
  typedef logic [LEN_WIDTH-1:0] burstLenT;
  typedef logic [OFFSET_WIDTH-1:0] wordOffsetT;
  typedef logic [RESP_WIDTH-1:0] respT;

  localparam respT RESP_OKAY = 2'b00;

  // Control-page flag, offset, ID, last flag
  localparam int BEAT_WIDTH = 1 + OFFSET_WIDTH + ID_WIDTH + 1;

endpackage

`default_nettype wire

/* common/portalMapPkg.sv */
`default_nettype none

package portalMapPkg;

  // Control page offsets
  localparam logic [4:0] CTRL_INT_STATUS = 5'h00;
  localparam logic [4:0] CTRL_INT_ENABLE = 5'h04;
  localparam logic [4:0] CTRL_NUM_TILES = 5'h08;
  localparam logic [4:0] CTRL_QUEUE_COUNT = 5'h0C;
  localparam logic [4:0] CTRL_PORTAL_ID = 5'h10;
  localparam logic [4:0] CTRL_NUM_PORTALS = 5'h14;
  localparam logic [4:0] CTRL_COUNTER_MSB = 5'h18;
  localparam logic [4:0] CTRL_COUNTER_LSB = 5'h1C;

  // FIFO page offsets
  localparam logic [4:0] FIFO_DATA = 5'h00;
  localparam logic [4:0] FIFO_STATUS = 5'h04;

  localparam logic [31:0] NUM_TILES = 32'd1;
  localparam logic [31:0] PORTAL_ID = 32'd5;
  localparam logic [31:0] NUM_PORTALS = 32'd2;
  localparam logic [31:0] UNMAPPED_VALUE = 32'h005A05A0;

  // Loopback queue standing in for the user core
  localparam int QUEUE_DEPTH = 4;

  typedef logic [2:0] queueCountT;

endpackage

`default_nettype wire

/* logic/syncFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 2
) (
  input  logic                        CLK,
  input  logic                        RST_N,
  input  logic                        inValid,
  output logic                        inReady,
  input  logic [WIDTH-1:0]            inData,
  output logic                        outValid,
  input  logic                        outReady,
  output logic [WIDTH-1:0]            outData,
  output logic [$clog2(DEPTH+1)-1:0]  count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] stepPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign inReady = (count != CNT_W'(DEPTH));
  assign outValid = (count != '0);
  assign outData = mem[rdPtr];
  assign push = inValid && inReady;
  assign pop = outValid && outReady;

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= stepPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= stepPtr(rdPtr);
      end
      // Simultaneous push and pop leaves occupancy unchanged
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/burstSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module burstSequencer (
  input  logic                     CLK,
  input  logic                     RST_N,
  input  logic                     addrValid,
  output logic                     addrReady,
  input  portalBusPkg::busAddrT    addr,
  input  portalBusPkg::burstLenT   len,
  input  portalBusPkg::busIdT      id,
  output logic                     beatValid,
  input  logic                     beatReady,
  output logic                     beatCtrlPage,
  output portalBusPkg::wordOffsetT beatOffset,
  output portalBusPkg::busIdT      beatId,
  output logic                     beatLast
);

  import portalBusPkg::*;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_ISSUE
  } seqStateT;

  seqStateT state;
  burstLenT remaining;
  logic addrTaken;
  logic beatTaken;

  assign addrReady = (state == SEQ_IDLE);
  assign beatValid = (state == SEQ_ISSUE);
  assign beatLast = (remaining == '0);
  assign addrTaken = addrValid && addrReady;
  assign beatTaken = beatValid && beatReady;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= SEQ_IDLE;
    end else begin
      case (state)
        SEQ_IDLE: if (addrTaken) state <= SEQ_ISSUE;
        SEQ_ISSUE: if (beatTaken && beatLast) state <= SEQ_IDLE;
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (addrTaken) begin
      // Page select from bits 11 to 5
      beatCtrlPage <= (addr[11:5] == 7'd0);
      beatOffset <= addr[4:0];
      beatId <= id;
      remaining <= len;
    end else if (beatTaken) begin
      // Offset wraps within the 32-byte page
      beatOffset <= beatOffset + wordOffsetT'(4);
      remaining <= remaining - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* portal/portalReadResponder.sv */
`timescale 1ns/1ps
`default_nettype none

module portalReadResponder (
  input  logic                     CLK,
  input  logic                     RST_N,
  input  logic                     beatValid,
  output logic                     beatReady,
  input  logic                     beatCtrlPage,
  input  portalBusPkg::wordOffsetT beatOffset,
  input  portalBusPkg::busIdT      beatId,
  input  logic                     beatLast,
  input  logic                     intEnable,
  input  portalMapPkg::queueCountT queueCount,
  input  logic                     queueValid,
  input  portalBusPkg::busDataT    queueData,
  output logic                     queueReady,
  output logic                     rValid,
  input  logic                     rReady,
  output portalBusPkg::busDataT    rData,
  output portalBusPkg::busIdT      rId,
  output logic                     rLast
);

  import portalBusPkg::*;
  import portalMapPkg::*;

  busDataT ctrlWord;
  busDataT fifoWord;
  logic takeBeat;

  // Output register free now or draining this cycle
  assign beatReady = !rValid || rReady;
  assign takeBeat = beatValid && beatReady;
  assign queueReady = takeBeat && !beatCtrlPage && (beatOffset == FIFO_DATA);

  always_comb begin
    case (beatOffset)
      CTRL_INT_STATUS: ctrlWord = busDataT'(queueValid);
      CTRL_INT_ENABLE: ctrlWord = busDataT'(intEnable);
      CTRL_NUM_TILES: ctrlWord = NUM_TILES;
      CTRL_QUEUE_COUNT: ctrlWord = busDataT'(queueCount);
      CTRL_PORTAL_ID: ctrlWord = PORTAL_ID;
      CTRL_NUM_PORTALS: ctrlWord = NUM_PORTALS;
      CTRL_COUNTER_MSB: ctrlWord = '0;
      CTRL_COUNTER_LSB: ctrlWord = '0;
      default: ctrlWord = UNMAPPED_VALUE;
    endcase
  end

  always_comb begin
    case (beatOffset)
      // Empty queue reads as zero
      FIFO_DATA: fifoWord = queueValid ? queueData : '0;
      FIFO_STATUS: fifoWord = busDataT'(queueValid);
      default: fifoWord = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rValid <= 1'b0;
    end else if (takeBeat) begin
      rValid <= 1'b1;
    end else if (rReady) begin
      rValid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (takeBeat) begin
      rData <= beatCtrlPage ? ctrlWord : fifoWord;
      rId <= beatId;
      rLast <= beatLast;
    end
  end

endmodule

`default_nettype wire

/* portal/portalWriteResponder.sv */
`timescale 1ns/1ps
`default_nettype none

module portalWriteResponder (
  input  logic                     CLK,
  input  logic                     RST_N,
  input  logic                     beatValid,
  output logic                     beatReady,
  input  logic                     beatCtrlPage,
  input  portalBusPkg::wordOffsetT beatOffset,
  input  portalBusPkg::busIdT      beatId,
  input  logic                     beatLast,
  input  logic                     dataValid,
  output logic                     dataReady,
  input  portalBusPkg::busDataT    data,
  output logic                     queueValid,
  input  logic                     queueReady,
  output portalBusPkg::busDataT    queueData,
  output logic                     intEnable,
  output logic                     bValid,
  input  logic                     bReady,
  output portalBusPkg::busIdT      bId,
  output portalBusPkg::respT       bResp
);

  import portalBusPkg::*;
  import portalMapPkg::*;

  logic isQueuePush;
  logic isEnableWrite;
  logic slotFree;
  logic pairReady;
  logic consume;

  assign isQueuePush = !beatCtrlPage && (beatOffset == FIFO_DATA);
  assign isEnableWrite = beatCtrlPage && (beatOffset == CTRL_INT_ENABLE);
  assign slotFree = !bValid || bReady;

  // Beat and data word leave together
  assign pairReady = beatValid && dataValid && (!beatLast || slotFree);
  assign consume = pairReady && (!isQueuePush || queueReady);

  assign beatReady = consume;
  assign dataReady = consume;
  assign queueValid = pairReady && isQueuePush;
  assign queueData = data;
  assign bResp = RESP_OKAY;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      intEnable <= 1'b0;
      bValid <= 1'b0;
    end else begin
      if (consume && isEnableWrite) begin
        intEnable <= data[0];
      end
      if (consume && beatLast) begin
        bValid <= 1'b1;
      end else if (bReady) begin
        bValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (consume && beatLast) begin
      bId <= busIdT'(beatId);
    end
  end

endmodule

`default_nettype wire

/* portal/portalTop.sv */
`timescale 1ns/1ps
`default_nettype none

module portalTop (
  input  logic                   CLK,
  input  logic                   RST_N,
  input  logic                   arValid,
  output logic                   arReady,
  input  portalBusPkg::busAddrT  arAddr,
  input  portalBusPkg::burstLenT arLen,
  input  portalBusPkg::busIdT    arId,
  output logic                   rValid,
  input  logic                   rReady,
  output portalBusPkg::busDataT  rData,
  output portalBusPkg::busIdT    rId,
  output logic                   rLast,
  input  logic                   awValid,
  output logic                   awReady,
  input  portalBusPkg::busAddrT  awAddr,
  input  portalBusPkg::burstLenT awLen,
  input  portalBusPkg::busIdT    awId,
  input  logic                   wValid,
  output logic                   wReady,
  input  portalBusPkg::busDataT  wData,
  output logic                   bValid,
  input  logic                   bReady,
  output portalBusPkg::busIdT    bId,
  output portalBusPkg::respT     bResp,
  output logic                   irq
);

  import portalBusPkg::*;
  import portalMapPkg::*;

  // Read path
  logic rdSeqValid, rdSeqReady, rdSeqCtrl, rdSeqLast;
  wordOffsetT rdSeqOffset;
  busIdT rdSeqId;
  logic [BEAT_WIDTH-1:0] rdSeqBeat, rdBeat;
  logic rdBeatValid, rdBeatReady;

  // Write path
  logic wrSeqValid, wrSeqReady, wrSeqCtrl, wrSeqLast;
  wordOffsetT wrSeqOffset;
  busIdT wrSeqId;
  logic [BEAT_WIDTH-1:0] wrSeqBeat, wrBeat;
  logic wrBeatValid, wrBeatReady;
  logic wrDataValid, wrDataReady;
  busDataT wrDataWord;

  // Loopback queue between the responders
  logic pushValid, pushReady, popValid, popReady;
  busDataT pushData, popData;
  queueCountT queueCount;
  logic intEnable;

  assign rdSeqBeat = {rdSeqCtrl, rdSeqOffset, rdSeqId, rdSeqLast};
  assign wrSeqBeat = {wrSeqCtrl, wrSeqOffset, wrSeqId, wrSeqLast};
  assign irq = intEnable && popValid;

  burstSequencer readSeq (
    .CLK(CLK), .RST_N(RST_N),
    .addrValid(arValid), .addrReady(arReady), .addr(arAddr), .len(arLen), .id(arId),
    .beatValid(rdSeqValid), .beatReady(rdSeqReady), .beatCtrlPage(rdSeqCtrl),
    .beatOffset(rdSeqOffset), .beatId(rdSeqId), .beatLast(rdSeqLast)
  );

  syncFifo #(.WIDTH(BEAT_WIDTH), .DEPTH(2)) readBeatFifo (
    .CLK(CLK), .RST_N(RST_N),
    .inValid(rdSeqValid), .inReady(rdSeqReady), .inData(rdSeqBeat),
    .outValid(rdBeatValid), .outReady(rdBeatReady), .outData(rdBeat), .count()
  );

  portalReadResponder readResp (
    .CLK(CLK), .RST_N(RST_N),
    .beatValid(rdBeatValid), .beatReady(rdBeatReady), .beatCtrlPage(rdBeat[12]),
    .beatOffset(rdBeat[11:7]), .beatId(rdBeat[6:1]), .beatLast(rdBeat[0]),
    .intEnable(intEnable), .queueCount(queueCount),
    .queueValid(popValid), .queueData(popData), .queueReady(popReady),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast)
  );

  burstSequencer writeSeq (
    .CLK(CLK), .RST_N(RST_N),
    .addrValid(awValid), .addrReady(awReady), .addr(awAddr), .len(awLen), .id(awId),
    .beatValid(wrSeqValid), .beatReady(wrSeqReady), .beatCtrlPage(wrSeqCtrl),
    .beatOffset(wrSeqOffset), .beatId(wrSeqId), .beatLast(wrSeqLast)
  );

  syncFifo #(.WIDTH(BEAT_WIDTH), .DEPTH(2)) writeBeatFifo (
    .CLK(CLK), .RST_N(RST_N),
    .inValid(wrSeqValid), .inReady(wrSeqReady), .inData(wrSeqBeat),
    .outValid(wrBeatValid), .outReady(wrBeatReady), .outData(wrBeat), .count()
  );

  // Write data is buffered apart from the address
  syncFifo #(.WIDTH($bits(busDataT)), .DEPTH(2)) writeDataFifo (
    .CLK(CLK), .RST_N(RST_N),
    .inValid(wValid), .inReady(wReady), .inData(wData),
    .outValid(wrDataValid), .outReady(wrDataReady), .outData(wrDataWord), .count()
  );

  portalWriteResponder writeResp (
    .CLK(CLK), .RST_N(RST_N),
    .beatValid(wrBeatValid), .beatReady(wrBeatReady), .beatCtrlPage(wrBeat[12]),
    .beatOffset(wrBeat[11:7]), .beatId(wrBeat[6:1]), .beatLast(wrBeat[0]),
    .dataValid(wrDataValid), .dataReady(wrDataReady), .data(wrDataWord),
    .queueValid(pushValid), .queueReady(pushReady), .queueData(pushData),
    .intEnable(intEnable),
    .bValid(bValid), .bReady(bReady), .bId(bId), .bResp(bResp)
  );

  syncFifo #(.WIDTH($bits(busDataT)), .DEPTH(QUEUE_DEPTH)) loopbackFifo (
    .CLK(CLK), .RST_N(RST_N),
    .inValid(pushValid), .inReady(pushReady), .inData(pushData),
    .outValid(popValid), .outReady(popReady), .outData(popData), .count(queueCount)
  );

endmodule

`default_nettype wire

/* dv/portalTb_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module portalTb_properties (
  input logic                     CLK,
  input logic                     RST_N,
  input logic                     rValid,
  input logic                     rReady,
  input portalBusPkg::busDataT    rData,
  input portalBusPkg::busIdT      rId,
  input logic                     rLast,
  input logic                     bValid,
  input logic                     bReady,
  input portalBusPkg::busIdT      bId,
  input portalBusPkg::respT       bResp,
  input logic                     intEnable,
  input portalMapPkg::queueCountT queueCount,
  input logic                     pushValid,
  input logic                     pushReady,
  input logic                     popValid,
  input logic                     popReady,
  input logic                     irq
);

  // Held read beat keeps its payload
  rHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    rValid && !rReady |=> rValid && $stable(rData) && $stable(rId) && $stable(rLast))
    else $error("read data changed while stalled");

  bHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    bValid && !bReady |=> bValid && $stable(bId) && $stable(bResp))
    else $error("write response changed while stalled");

  // Push with the enable set raises irq
  irqOnPush: assert property (@(posedge CLK) disable iff (!RST_N)
    intEnable && pushValid && pushReady |=> irq)
    else $error("irq low after a push with the interrupt enabled");

  // Popping the last word drops irq
  irqOnDrain: assert property (@(posedge CLK) disable iff (!RST_N)
    popValid && popReady && !(pushValid && pushReady) && queueCount == 3'd1 |=> !irq)
    else $error("irq high after the queue drained");

  resetQuiet: assert property (@(posedge CLK) !RST_N |=> !rValid && !bValid)
    else $error("response valid high after reset");

endmodule

bind portalTop portalTb_properties props (
  .CLK(CLK), .RST_N(RST_N),
  .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
  .bValid(bValid), .bReady(bReady), .bId(bId), .bResp(bResp),
  .intEnable(intEnable), .queueCount(queueCount),
  .pushValid(pushValid), .pushReady(pushReady),
  .popValid(popValid), .popReady(popReady), .irq(irq)
);

`default_nettype wire

/* dv/portalTb.sv */
`timescale 1ns/1ps
`default_nettype none

module portalTb;

  import portalBusPkg::*;
  import portalMapPkg::*;

  localparam int TIMEOUT = 200;
  localparam busAddrT FIFO_PAGE = 32'h0000_0040;

  logic CLK;
  logic RST_N;
  logic arValid;
  logic arReady;
  busAddrT arAddr;
  burstLenT arLen;
  busIdT arId;
  logic rValid;
  logic rReady;
  busDataT rData;
  busIdT rId;
  logic rLast;
  logic awValid;
  logic awReady;
  busAddrT awAddr;
  burstLenT awLen;
  busIdT awId;
  logic wValid;
  logic wReady;
  busDataT wData;
  logic bValid;
  logic bReady;
  busIdT bId;
  respT bResp;
  logic irq;

  logic [31:0] lfsrState;
  busDataT modelQueue[$];
  logic modelEnable;
  logic runPassed;
  logic failReported;

  portalTop uut (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Galois LFSR stepped once per bit handed out
  function automatic logic takeBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
    return outBit;
  endfunction

  function automatic busDataT randomWord();
    busDataT w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], takeBit()};
    end
    return w;
  endfunction

  // Reference map that pops the queue model on a data read
  function automatic busDataT expectedWord(input logic ctrl, input wordOffsetT offset);
    busDataT w;
    logic notEmpty;
    notEmpty = (modelQueue.size() != 0);
    w = '0;
    if (ctrl) begin
      case (offset)
        CTRL_INT_STATUS: w = busDataT'(notEmpty);
        CTRL_INT_ENABLE: w = busDataT'(modelEnable);
        CTRL_NUM_TILES: w = 32'd1;
        CTRL_QUEUE_COUNT: w = busDataT'(modelQueue.size());
        CTRL_PORTAL_ID: w = 32'd5;
        CTRL_NUM_PORTALS: w = 32'd2;
        CTRL_COUNTER_MSB: w = '0;
        CTRL_COUNTER_LSB: w = '0;
        default: w = 32'h005A_05A0;
      endcase
    end else if (offset == FIFO_DATA && notEmpty) begin
      w = modelQueue.pop_front();
    end else if (offset == FIFO_STATUS) begin
      w = busDataT'(notEmpty);
    end
    return w;
  endfunction

  task automatic failRun(input string why);
    failReported = 1'b1;
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string what, input busDataT got, input busDataT expected);
    assert (got == expected) else begin
      failRun($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected));
    end
  endtask

  task automatic nextCycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic checkIrq();
    checkValue("irq", busDataT'(irq), busDataT'(modelEnable && modelQueue.size() != 0));
  endtask

  task automatic sendAddr(input logic isWrite, input busAddrT addr, input burstLenT len,
                          input busIdT id);
    int waited;
    waited = 0;
    if (isWrite) begin
      awValid = 1'b1;
      awAddr = addr;
      awLen = len;
      awId = id;
    end else begin
      arValid = 1'b1;
      arAddr = addr;
      arLen = len;
      arId = id;
    end
    @(negedge CLK);
    while (!(isWrite ? awReady : arReady)) begin
      waited++;
      if (waited > TIMEOUT) begin
        failRun("Timed out waiting for the address channel to accept a request");
      end
      @(negedge CLK);
    end
    nextCycle();
    arValid = 1'b0;
    awValid = 1'b0;
  endtask

  task automatic readBurst(input busAddrT addr, input burstLenT len, input busIdT id,
                           input logic stall);
    logic ctrl;
    wordOffsetT offset;
    int waited;
    ctrl = (addr[11:5] == 7'd0);
    offset = addr[4:0];
    sendAddr(1'b0, addr, len, id);
    for (int beat = 0; beat <= int'(len); beat++) begin
      waited = 0;
      rReady = stall ? takeBit() : 1'b1;
      @(negedge CLK);
      while (!(rValid && rReady)) begin
        waited++;
        if (waited > TIMEOUT) begin
          failRun("Timed out waiting for read data");
        end
        nextCycle();
        rReady = stall ? takeBit() : 1'b1;
        @(negedge CLK);
      end
      checkValue("rData", rData, expectedWord(ctrl, offset));
      checkValue("rId", busDataT'(rId), busDataT'(id));
      checkValue("rLast", busDataT'(rLast), busDataT'(beat == int'(len)));
      offset = offset + wordOffsetT'(4);
      nextCycle();
    end
    rReady = 1'b0;
  endtask

  task automatic writeBurst(input busAddrT addr, input burstLenT len, input busIdT id,
                            input busDataT value, input logic useRandom);
    logic ctrl;
    wordOffsetT offset;
    busDataT word;
    int waited;
    ctrl = (addr[11:5] == 7'd0);
    offset = addr[4:0];
    sendAddr(1'b1, addr, len, id);
    for (int beat = 0; beat <= int'(len); beat++) begin
      word = useRandom ? randomWord() : value;
      wValid = 1'b1;
      wData = word;
      waited = 0;
      @(negedge CLK);
      while (!wReady) begin
        waited++;
        if (waited > TIMEOUT) begin
          failRun("Timed out waiting for the write data channel");
        end
        @(negedge CLK);
      end
      nextCycle();
      wValid = 1'b0;
      if (ctrl && offset == CTRL_INT_ENABLE) begin
        modelEnable = word[0];
      end
      if (!ctrl && offset == FIFO_DATA) begin
        modelQueue.push_back(word);
      end
      offset = offset + wordOffsetT'(4);
    end
  endtask

  task automatic awaitResponse(input busIdT id, input logic stall);
    int waited;
    waited = 0;
    bReady = stall ? takeBit() : 1'b1;
    @(negedge CLK);
    while (!(bValid && bReady)) begin
      waited++;
      if (waited > TIMEOUT) begin
        failRun("Timed out waiting for a write response");
      end
      nextCycle();
      bReady = stall ? takeBit() : 1'b1;
      @(negedge CLK);
    end
    checkValue("bId", busDataT'(bId), busDataT'(id));
    checkValue("bResp", busDataT'(bResp), busDataT'(RESP_OKAY));
    nextCycle();
    bReady = 1'b0;
    // A burst yields one response only
    checkValue("bValid after response", busDataT'(bValid), '0);
  endtask

  initial begin
    busDataT word;
    lfsrState = 32'd88;
    modelEnable = 1'b0;
    runPassed = 1'b0;
    failReported = 1'b0;
    RST_N = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    rReady = 1'b0;
    awValid = 1'b0;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    wValid = 1'b0;
    wData = '0;
    bReady = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    RST_N = 1'b1;
    nextCycle();

    // Control page map and offset wrap with stalls
    readBurst(32'h0000_0000, 4'd7, 6'h11, 1'b0);
    readBurst(32'h0000_0018, 4'd9, 6'h12, 1'b1);

    // Multi-beat control writes
    writeBurst(32'h0000_0008, 4'd3, 6'h21, '0, 1'b1);
    awaitResponse(6'h21, 1'b1);
    writeBurst(32'h0000_0000, 4'd7, 6'h22, '0, 1'b1);
    awaitResponse(6'h22, 1'b1);
    writeBurst(32'h0000_0004, 4'd0, 6'h23, 32'd0, 1'b0);
    awaitResponse(6'h23, 1'b0);
    readBurst(32'h0000_0000, 4'd7, 6'h13, 1'b0);

    // Loopback order and occupancy
    for (int i = 0; i < 2; i++) begin
      writeBurst(FIFO_PAGE, 4'd0, 6'h30, '0, 1'b1);
      awaitResponse(6'h30, 1'b0);
    end
    readBurst(FIFO_PAGE + 32'd4, 4'd0, 6'h14, 1'b0);
    readBurst(32'h0000_000C, 4'd0, 6'h15, 1'b0);
    readBurst(FIFO_PAGE, 4'd0, 6'h16, 1'b1);
    readBurst(32'h0000_000C, 4'd0, 6'h15, 1'b0);
    readBurst(FIFO_PAGE, 4'd0, 6'h16, 1'b1);
    readBurst(FIFO_PAGE, 4'd0, 6'h17, 1'b0);
    readBurst(FIFO_PAGE + 32'd4, 4'd0, 6'h14, 1'b0);

    // Full queue holds back the next write
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      writeBurst(FIFO_PAGE, 4'd0, 6'h31, '0, 1'b1);
      awaitResponse(6'h31, 1'b1);
    end
    readBurst(32'h0000_000C, 4'd0, 6'h18, 1'b0);
    writeBurst(FIFO_PAGE, 4'd0, 6'h32, '0, 1'b1);
    repeat (20) begin
      nextCycle();
      checkValue("bValid while queue full", busDataT'(bValid), '0);
    end
    readBurst(FIFO_PAGE, 4'd0, 6'h19, 1'b1);
    awaitResponse(6'h32, 1'b1);
    for (int i = 0; i < QUEUE_DEPTH + 1; i++) begin
      readBurst(FIFO_PAGE, 4'd0, 6'h1A, 1'b1);
    end

    // Interrupt follows enable and queue state
    word = randomWord();
    writeBurst(FIFO_PAGE, 4'd0, 6'h33, word, 1'b0);
    awaitResponse(6'h33, 1'b0);
    checkIrq();
    writeBurst(32'h0000_0004, 4'd0, 6'h34, 32'd1, 1'b0);
    awaitResponse(6'h34, 1'b0);
    checkIrq();
    readBurst(32'h0000_0000, 4'd1, 6'h1B, 1'b0);
    readBurst(FIFO_PAGE, 4'd0, 6'h1C, 1'b0);
    checkIrq();
    writeBurst(FIFO_PAGE, 4'd0, 6'h35, '0, 1'b1);
    awaitResponse(6'h35, 1'b0);
    checkIrq();
    writeBurst(32'h0000_0004, 4'd0, 6'h36, 32'd0, 1'b0);
    awaitResponse(6'h36, 1'b0);
    checkIrq();
    readBurst(FIFO_PAGE, 4'd0, 6'h1D, 1'b0);
    checkIrq();

    runPassed = 1'b1;
    $display("STATUS: PASS");
    $finish;
  end

  final begin
    if (!runPassed && !failReported) begin
      $display("STATUS: FAIL");
    end
  end

endmodule

`default_nettype wire

/* list.f */
common/portalBusPkg.sv
common/portalMapPkg.sv
logic/syncFifo.sv
logic/burstSequencer.sv
portal/portalReadResponder.sv
portal/portalWriteResponder.sv
portal/portalTop.sv
dv/portalTb_properties.sv
dv/portalTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module portalTb -f list.f -Mdir obj_dir -o portalSim

# The simulator status is masked by tee, so the log decides
./obj_dir/portalSim 2>&1 | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1
